//--- rtl/ram_init_pkg.sv
package ram_init_pkg;

	// ========================================
	// Widths
	// ========================================

	// One word of a work memory
	typedef logic [7:0] byte_t;

	// Power-on pattern selector of one bank
	typedef logic [1:0] fill_mode_t;

	localparam fill_mode_t FILL_9966 = 2'd0;
	localparam fill_mode_t FILL_00FF = 2'd1;
	localparam fill_mode_t FILL_55   = 2'd2;
	localparam fill_mode_t FILL_FF   = 2'd3;

	// ========================================
	// Pattern bytes
	// ========================================

	localparam byte_t PAT_9966_LO = 8'h99;
	localparam byte_t PAT_9966_HI = 8'h66;
	localparam byte_t PAT_00FF_LO = 8'h00;
	localparam byte_t PAT_00FF_HI = 8'hFF;
	localparam byte_t PAT_55      = 8'h55;
	localparam byte_t PAT_FF      = 8'hFF;

	// Clear sequencer states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		WRITE = 2'd1,
		HOLD  = 2'd2
	} clear_state_e;

	localparam int NUM_BANKS_DEF      = 4;
	localparam int BANK_ADDR_BITS_DEF = 10;

endpackage

//--- rtl/clear_sequencer.sv
`timescale 1ns/1ns

module clear_sequencer #(
	parameter int bank_addr_bits = ram_init_pkg::BANK_ADDR_BITS_DEF
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      start_clear,
	output logic                      busy,
	output logic [bank_addr_bits-1:0] fill_addr,
	output logic                      fill_we
);

	import ram_init_pkg::*;

	localparam logic [bank_addr_bits-1:0] last_addr = '1;

	clear_state_e state;

	// ========================================
	// Address walk
	// ========================================

	// One write cycle then one idle cycle per word
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= IDLE;
			fill_addr <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Start pulses are only seen here, so a pulse during a clear is dropped
					if (start_clear) begin
						state     <= WRITE;
						fill_addr <= '0;
					end
				end
				WRITE: begin
					state <= HOLD;
				end
				HOLD: begin
					if (fill_addr == last_addr) begin
						state <= IDLE;
					end else begin
						fill_addr <= fill_addr + 1'b1;
						state     <= WRITE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Busy spans every WRITE and HOLD cycle of the pass
	assign busy    = (state != IDLE);
	assign fill_we = (state == WRITE);

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder #(
	parameter int num_banks      = ram_init_pkg::NUM_BANKS_DEF,
	parameter int bank_addr_bits = ram_init_pkg::BANK_ADDR_BITS_DEF,
	localparam int idx_bits      = (num_banks > 1) ? $clog2(num_banks) : 1,
	localparam int adr_bits      = bank_addr_bits + idx_bits
) (
	input  logic                      clk_sys,
	input  logic                      RESET,

	// Wishbone classic request side
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [adr_bits-1:0]       wb_adr,
	input  ram_init_pkg::byte_t       wb_dat_w,

	input  logic                      busy,

	// Bank access, valid for one cycle
	output logic [num_banks-1:0]      bank_sel,
	output logic [bank_addr_bits-1:0] bank_addr,
	output logic                      bank_we,
	output logic                      bank_re,
	output ram_init_pkg::byte_t       bank_wdata,

	// To the read collector
	output logic                      issue,
	output logic [idx_bits-1:0]       issue_idx
);

	logic                      pending;
	logic                      accept;
	logic [idx_bits-1:0]       req_idx;
	logic [bank_addr_bits-1:0] req_addr;
	logic [num_banks-1:0]      req_sel;

	// ========================================
	// Address split
	// ========================================

	// Upper bits pick the bank, lower bits the word
	assign req_addr = wb_adr[bank_addr_bits-1:0];
	assign req_idx  = wb_adr[adr_bits-1:bank_addr_bits];

	// An index past the last bank selects nothing
	always_comb begin
		req_sel = '0;
		for (int i = 0; i < num_banks; i++) begin
			if (req_idx == idx_bits'(i)) begin
				req_sel[i] = 1'b1;
			end
		end
	end

	// Host is held off for the whole clear
	assign accept = wb_cyc && wb_stb && !busy && !pending;

	// ========================================
	// Issue
	// ========================================

	// Pending covers the access cycle and the ack cycle
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pending  <= 1'b0;
			issue    <= 1'b0;
			bank_sel <= '0;
			bank_we  <= 1'b0;
			bank_re  <= 1'b0;
		end else begin
			issue    <= accept;
			bank_sel <= accept ? req_sel : '0;
			bank_we  <= accept && wb_we;
			bank_re  <= accept && !wb_we;
			if (accept) begin
				pending <= 1'b1;
			end else if (!issue) begin
				pending <= 1'b0;
			end
		end
	end

	// Address, data and index of the accepted request
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			bank_addr  <= req_addr;
			bank_wdata <= wb_dat_w;
			issue_idx  <= req_idx;
		end
	end

endmodule

//--- rtl/work_ram_bank.sv
`timescale 1ns/1ns

module work_ram_bank #(
	parameter int bank_addr_bits = ram_init_pkg::BANK_ADDR_BITS_DEF
) (
	input  logic                      clk_sys,

	// Clear path
	input  ram_init_pkg::fill_mode_t  fill_mode,
	input  logic [bank_addr_bits-1:0] fill_addr,
	input  logic                      fill_we,

	// Host path
	input  logic                      sel,
	input  logic                      we,
	input  logic                      re,
	input  logic [bank_addr_bits-1:0] addr,
	input  ram_init_pkg::byte_t       wdata,
	output ram_init_pkg::byte_t       rdata
);

	import ram_init_pkg::*;

	// Address bits that shape the two striped patterns
	localparam int mode0_bit_hi = 8;
	localparam int mode0_bit_lo = 2;
	localparam int mode1_bit_hi = 9;
	localparam int mode1_bit_lo = 0;

	localparam int depth = 2 ** bank_addr_bits;

	byte_t mem [depth];
	byte_t fill_data;
	logic  mode0_flip;
	logic  mode1_flip;

	// ========================================
	// Fill pattern
	// ========================================

	assign mode0_flip = fill_addr[mode0_bit_hi] ^ fill_addr[mode0_bit_lo];
	assign mode1_flip = fill_addr[mode1_bit_hi] ^ fill_addr[mode1_bit_lo];

	always_comb begin
		case (fill_mode)
			FILL_9966: begin
				fill_data = mode0_flip ? PAT_9966_HI : PAT_9966_LO;
			end
			FILL_00FF: begin
				fill_data = mode1_flip ? PAT_00FF_HI : PAT_00FF_LO;
			end
			FILL_55: begin
				fill_data = PAT_55;
			end
			default: begin
				fill_data = PAT_FF;
			end
		endcase
	end

	// ========================================
	// Storage
	// ========================================

	// Clear writes take the port ahead of the host
	always_ff @(posedge clk_sys) begin
		if (fill_we) begin
			mem[fill_addr] <= fill_data;
		end else if (sel && we) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read, one cycle after the access
	always_ff @(posedge clk_sys) begin
		if (sel && re) begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- rtl/read_collector.sv
`timescale 1ns/1ns

module read_collector #(
	parameter int num_banks = ram_init_pkg::NUM_BANKS_DEF,
	localparam int idx_bits = (num_banks > 1) ? $clog2(num_banks) : 1
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                issue,
	input  logic [idx_bits-1:0] issue_idx,
	input  logic                issue_read,
	input  ram_init_pkg::byte_t bank_rdata [num_banks],
	output logic                wb_ack,
	output ram_init_pkg::byte_t wb_dat_r
);

	import ram_init_pkg::*;

	logic                ack_q;
	logic                read_q;
	logic [idx_bits-1:0] idx_q;
	byte_t               sel_byte;

	// Line up with the registered bank data
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ack_q  <= 1'b0;
			read_q <= 1'b0;
		end else begin
			ack_q  <= issue;
			read_q <= issue && issue_read;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			idx_q <= issue_idx;
		end
	end

	always_comb begin
		sel_byte = '0;
		for (int i = 0; i < num_banks; i++) begin
			if (idx_q == idx_bits'(i)) begin
				sel_byte = bank_rdata[i];
			end
		end
	end

	// Writes return zero data
	assign wb_ack   = ack_q;
	assign wb_dat_r = read_q ? sel_byte : '0;

endmodule

//--- rtl/ram_init_top.sv
`timescale 1ns/1ns

module ram_init_top #(
	parameter int num_banks      = ram_init_pkg::NUM_BANKS_DEF,
	parameter int bank_addr_bits = ram_init_pkg::BANK_ADDR_BITS_DEF,
	localparam int idx_bits      = (num_banks > 1) ? $clog2(num_banks) : 1,
	localparam int adr_bits      = bank_addr_bits + idx_bits
) (
	input  logic                                     clk_sys,
	input  logic                                     RESET,

	// Clear control
	input  logic                                     start_clear,
	input  ram_init_pkg::fill_mode_t [num_banks-1:0] fill_modes,
	output logic                                     busy,

	// Wishbone classic slave
	input  logic                                     wb_cyc,
	input  logic                                     wb_stb,
	input  logic                                     wb_we,
	input  logic [adr_bits-1:0]                      wb_adr,
	input  ram_init_pkg::byte_t                      wb_dat_w,
	output ram_init_pkg::byte_t                      wb_dat_r,
	output logic                                     wb_ack
);

	import ram_init_pkg::*;

	logic [bank_addr_bits-1:0] fill_addr;
	logic                      fill_we;

	logic [num_banks-1:0]      bank_sel;
	logic [bank_addr_bits-1:0] bank_addr;
	logic                      bank_we;
	logic                      bank_re;
	byte_t                     bank_wdata;
	byte_t                     bank_rdata [num_banks];

	logic                      issue;
	logic [idx_bits-1:0]       issue_idx;

	clear_sequencer #(
		.bank_addr_bits(bank_addr_bits)
	) u_clear_sequencer (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.start_clear (start_clear),
		.busy        (busy),
		.fill_addr   (fill_addr),
		.fill_we     (fill_we)
	);

	bus_decoder #(
		.num_banks      (num_banks),
		.bank_addr_bits (bank_addr_bits)
	) u_bus_decoder (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.busy       (busy),
		.bank_sel   (bank_sel),
		.bank_addr  (bank_addr),
		.bank_we    (bank_we),
		.bank_re    (bank_re),
		.bank_wdata (bank_wdata),
		.issue      (issue),
		.issue_idx  (issue_idx)
	);

	// ========================================
	// Banks
	// ========================================

	// Shared fill walk, each bank with its own pattern
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		work_ram_bank #(
			.bank_addr_bits(bank_addr_bits)
		) u_bank (
			.clk_sys   (clk_sys),
			.fill_mode (fill_modes[i]),
			.fill_addr (fill_addr),
			.fill_we   (fill_we),
			.sel       (bank_sel[i]),
			.we        (bank_we),
			.re        (bank_re),
			.addr      (bank_addr),
			.wdata     (bank_wdata),
			.rdata     (bank_rdata[i])
		);
	end

	read_collector #(
		.num_banks(num_banks)
	) u_read_collector (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.issue      (issue),
		.issue_idx  (issue_idx),
		.issue_read (bank_re),
		.bank_rdata (bank_rdata),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r)
	);

endmodule

//--- verification/ram_init_assert.sv
`timescale 1ns/1ns

module ram_init_assert (
	input logic clk_sys,
	input logic RESET,
	input logic start_clear,
	input logic busy,
	input logic fill_we,
	input logic wb_ack
);

	// ========================================
	// Bus
	// ========================================

	ack_outside_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		wb_ack |-> !busy)
		else $error("wb_ack asserted while a clear is running");

	ack_single_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for two cycles");

	// ========================================
	// Clear sequence
	// ========================================

	// WRITE is always followed by HOLD
	fill_we_spaced: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |=> !fill_we)
		else $error("fill_we high in two consecutive cycles");

	busy_needs_start: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(busy) |-> $past(start_clear))
		else $error("busy rose without a start_clear pulse");

endmodule

//--- verification/ram_init_tb.sv
`timescale 1ns/1ns

module ram_init_tb;

	import ram_init_pkg::*;

	localparam int num_banks      = NUM_BANKS_DEF;
	localparam int bank_addr_bits = BANK_ADDR_BITS_DEF;
	localparam int idx_bits       = (num_banks > 1) ? $clog2(num_banks) : 1;
	localparam int depth          = 2 ** bank_addr_bits;
	localparam int clear_cycles   = 2 * depth;
	localparam int n_sample       = 256;
	localparam int n_writes       = 64;
	localparam int n_pairs        = 8;
	localparam int n_transfers    = num_banks * depth + n_sample + 4 * n_writes + 2 * n_pairs + 1;
	// Each transfer takes three cycles with the idle cycle after it
	localparam int timeout_cycles = 2 * (16 + 3 * clear_cycles + 3 * n_transfers);
	// Falling edges from request to ack, one for the bank access and one for the ack
	localparam int ack_latency    = 2;

	logic                             clk_sys;
	logic                             RESET;
	logic                             start_clear;
	fill_mode_t [num_banks-1:0]       fill_modes;
	logic                             busy;
	logic                             wb_cyc;
	logic                             wb_stb;
	logic                             wb_we;
	logic [idx_bits+bank_addr_bits-1:0] wb_adr;
	byte_t                            wb_dat_w;
	byte_t                            wb_dat_r;
	logic                             wb_ack;

	byte_t model [num_banks][depth];
	byte_t exp_q [$];
	string cur_test;
	int    cycle_count = 0;
	int    wr_bank [n_writes];
	int    wr_addr [n_writes];
	int    pick_bank;
	int    pick_addr;

	ram_init_top #(
		.num_banks      (num_banks),
		.bank_addr_bits (bank_addr_bits)
	) dut (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.start_clear (start_clear),
		.fill_modes  (fill_modes),
		.busy        (busy),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack)
	);

	bind ram_init_top ram_init_assert u_ram_init_assert (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.start_clear (start_clear),
		.busy        (busy),
		.fill_we     (fill_we),
		.wb_ack      (wb_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================
	// Reference and checks
	// ========================================

	// Power-on byte of a bank in a given fill mode
	function automatic byte_t expect_fill(fill_mode_t mode, int addr);
		logic [bank_addr_bits-1:0] a;
		a = bank_addr_bits'(addr);
		case (mode)
			2'd0: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic void fill_model();
		for (int b = 0; b < num_banks; b++) begin
			for (int a = 0; a < depth; a++) begin
				model[b][a] = expect_fill(fill_modes[b], a);
			end
		end
	endfunction

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(string name, int unsigned expected, int unsigned actual);
		if (expected != actual) begin
			stop_with_failure($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// Every ack pops the oldest outstanding transfer
	always @(negedge clk_sys) begin
		if (!RESET && wb_ack) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("ack seen with no transfer outstanding");
			end else begin
				check_value(cur_test, exp_q.pop_front(), wb_dat_r);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			stop_with_failure("timeout, the run went past its cycle limit");
		end
	end

	// ========================================
	// Stimulus tasks
	// ========================================

	task automatic wait_ack(string name);
		for (int i = 1; i <= ack_latency; i++) begin
			@(negedge clk_sys);
			if (wb_ack && i < ack_latency) begin
				stop_with_failure($sformatf("%s: ack came one cycle early", name));
			end
		end
		if (!wb_ack) begin
			stop_with_failure($sformatf("%s: no ack when one was due", name));
		end
	endtask

	// Called just after a falling edge, returns one idle cycle after the ack
	task automatic bus_transfer(bit write, int bank, int addr, byte_t data);
		exp_q.push_back(write ? 8'h00 : model[bank][addr]);
		if (write) begin
			model[bank][addr] = data;
		end
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = write;
		wb_adr   = {idx_bits'(bank), bank_addr_bits'(addr)};
		wb_dat_w = data;
		// Held off while a clear runs
		while (busy) begin
			if (wb_ack) begin
				stop_with_failure($sformatf("%s: ack while the clear was busy", cur_test));
			end
			@(negedge clk_sys);
		end
		wait_ack(cur_test);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic run_clear(string name, bit repulse);
		int busy_cycles;
		busy_cycles = 0;
		start_clear = 1'b1;
		@(negedge clk_sys);
		start_clear = 1'b0;
		while (busy) begin
			busy_cycles++;
			// Extra start pulse halfway through, to be ignored
			start_clear = repulse && (busy_cycles == depth);
			@(negedge clk_sys);
		end
		start_clear = 1'b0;
		check_value({name, " busy length"}, clear_cycles, busy_cycles);
		fill_model();
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		void'($urandom(32'hedbc_f7a4));
		RESET       = 1'b1;
		start_clear = 1'b0;
		fill_modes  = '0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		cur_test    = "reset";
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		cur_test = "fixed_mode_clear";
		for (int b = 0; b < num_banks; b++) begin
			fill_modes[b] = fill_mode_t'(b);
		end
		run_clear(cur_test, 1'b0);
		for (int b = 0; b < num_banks; b++) begin
			for (int a = 0; a < depth; a++) begin
				bus_transfer(1'b0, b, a, 8'h00);
			end
		end

		cur_test = "random_mode_clear";
		for (int b = 0; b < num_banks; b++) begin
			fill_modes[b] = fill_mode_t'($urandom_range(0, 3));
		end
		run_clear(cur_test, 1'b1);
		for (int i = 0; i < n_sample; i++) begin
			pick_bank = $urandom_range(0, num_banks - 1);
			pick_addr = $urandom_range(0, depth - 1);
			bus_transfer(1'b0, pick_bank, pick_addr, 8'h00);
		end

		cur_test = "write_readback";
		for (int i = 0; i < n_writes; i++) begin
			wr_bank[i] = $urandom_range(0, num_banks - 1);
			wr_addr[i] = $urandom_range(1, depth - 2);
			bus_transfer(1'b1, wr_bank[i], wr_addr[i], byte_t'($urandom));
		end
		for (int i = 0; i < n_writes; i++) begin
			bus_transfer(1'b0, wr_bank[i], wr_addr[i], 8'h00);
			bus_transfer(1'b0, wr_bank[i], wr_addr[i] - 1, 8'h00);
			bus_transfer(1'b0, wr_bank[i], wr_addr[i] + 1, 8'h00);
		end

		cur_test = "ack_timing";
		for (int i = 0; i < n_pairs; i++) begin
			pick_bank = $urandom_range(0, num_banks - 1);
			pick_addr = $urandom_range(0, depth - 1);
			bus_transfer(1'b1, pick_bank, pick_addr, byte_t'($urandom));
			bus_transfer(1'b0, pick_bank, pick_addr, 8'h00);
		end

		// Read issued mid-clear must return the new fill value
		cur_test = "back_pressure";
		for (int b = 0; b < num_banks; b++) begin
			fill_modes[b] = fill_modes[b] + 2'd1;
		end
		fill_model();
		start_clear = 1'b1;
		@(negedge clk_sys);
		start_clear = 1'b0;
		repeat (16) @(negedge clk_sys);
		pick_bank = $urandom_range(0, num_banks - 1);
		pick_addr = $urandom_range(0, depth - 1);
		bus_transfer(1'b0, pick_bank, pick_addr, 8'h00);

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- ram_init.f
rtl/ram_init_pkg.sv
rtl/clear_sequencer.sv
rtl/bus_decoder.sv
rtl/work_ram_bank.sv
rtl/read_collector.sv
rtl/ram_init_top.sv
verification/ram_init_assert.sv
verification/ram_init_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ram_init_tb
FILELIST  = ram_init.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED, no pass line"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
